/* compile.f */
design/fp_pkg.sv
design/fp_lzc.sv
design/fp_fma_mul.sv
design/fp_fma_add.sv
design/fp_fma.sv
verification/fp_fma_assert.sv
verification/fp_fma_tb.sv

/* design/fp_fma.sv */
`timescale 1ns/1ns

module fp_fma
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  fp_pkg::fp_word_t    a_i,
    input  fp_pkg::fp_word_t    b_i,
    input  fp_pkg::fp_word_t    c_i,
    input  fp_pkg::fma_op_e     op_i,
    input  fp_pkg::round_mode_e rnd_i,
    output fp_pkg::fp_word_t    result_o,
    output logic                round_bit_o,
    output logic                sticky_bit_o,
    output logic                invalid_o,
    output logic                overflow_o,
    output logic                done_o
);

    fp_pkg::fp_class_e                   a_cls;
    fp_pkg::fp_class_e                   b_cls;
    fp_pkg::fp_class_e                   c_cls;
    logic                                a_nan;
    logic                                b_nan;
    logic                                c_nan;
    logic                                a_inf;
    logic                                b_inf;
    logic                                c_inf;
    logic                                a_zero;
    logic                                b_zero;
    logic                                c_zero;
    logic                                snan_in;

    logic                                c_sign_eff;
    logic                                eff_sub;
    logic                                invalid;

    logic                                prod_sign;
    logic signed [fp_pkg::EXP_WIDTH+1:0] prod_exp;
    logic [fp_pkg::PROD_WIDTH-1:0]       prod_mant;

    logic                                sum_sign;
    logic [fp_pkg::EXP_WIDTH-1:0]        sum_exp;
    logic [fp_pkg::MANT_WIDTH-1:0]       sum_mant;
    logic                                sum_round;
    logic                                sum_sticky;
    logic                                sum_zero;
    logic                                sum_ovf;
    logic                                sum_ufl;

    fp_pkg::fp_word_t                    res_d;
    logic                                round_d;
    logic                                sticky_d;
    logic                                overflow_d;

    //////////////////////////////////////////////////////////////////////
    // classification
    //////////////////////////////////////////////////////////////////////

    assign a_cls = fp_pkg::fp_classify(a_i);
    assign b_cls = fp_pkg::fp_classify(b_i);
    assign c_cls = fp_pkg::fp_classify(c_i);

    assign a_nan  = (a_cls == fp_pkg::FP_QNAN) | (a_cls == fp_pkg::FP_SNAN);
    assign b_nan  = (b_cls == fp_pkg::FP_QNAN) | (b_cls == fp_pkg::FP_SNAN);
    assign c_nan  = (c_cls == fp_pkg::FP_QNAN) | (c_cls == fp_pkg::FP_SNAN);
    assign a_inf  = (a_cls == fp_pkg::FP_INF);
    assign b_inf  = (b_cls == fp_pkg::FP_INF);
    assign c_inf  = (c_cls == fp_pkg::FP_INF);
    assign a_zero = (a_cls == fp_pkg::FP_ZERO);
    assign b_zero = (b_cls == fp_pkg::FP_ZERO);
    assign c_zero = (c_cls == fp_pkg::FP_ZERO);

    assign snan_in = (a_cls == fp_pkg::FP_SNAN) | (b_cls == fp_pkg::FP_SNAN) |
                     (c_cls == fp_pkg::FP_SNAN);

    assign c_sign_eff = c_i[fp_pkg::FP_WIDTH-1] ^ (op_i == fp_pkg::FMSUB);
    assign eff_sub    = prod_sign ^ c_sign_eff;

    // inf*0, or inf-inf once the product is known to be infinite
    assign invalid = snan_in | (a_inf & b_zero) | (a_zero & b_inf) |
                     ((a_inf | b_inf) & ~a_nan & ~b_nan & c_inf & eff_sub);

    fp_fma_mul u_mul
    (
        .a_sign_i    (a_i[fp_pkg::FP_WIDTH-1]),
        .a_exp_i     (a_i[fp_pkg::FP_WIDTH-2 -: fp_pkg::EXP_WIDTH]),
        .a_mant_i    (a_i[fp_pkg::MANT_WIDTH-1:0]),
        .b_sign_i    (b_i[fp_pkg::FP_WIDTH-1]),
        .b_exp_i     (b_i[fp_pkg::FP_WIDTH-2 -: fp_pkg::EXP_WIDTH]),
        .b_mant_i    (b_i[fp_pkg::MANT_WIDTH-1:0]),
        .prod_sign_o (prod_sign),
        .prod_exp_o  (prod_exp),
        .prod_mant_o (prod_mant)
    );

    fp_fma_add u_add
    (
        .prod_sign_i  (prod_sign),
        .prod_exp_i   (prod_exp),
        .prod_mant_i  (prod_mant),
        .c_sign_i     (c_sign_eff),
        .c_exp_i      (c_i[fp_pkg::FP_WIDTH-2 -: fp_pkg::EXP_WIDTH]),
        .c_mant_i     (c_i[fp_pkg::MANT_WIDTH-1:0]),
        .eff_sub_i    (eff_sub),
        .rnd_i        (rnd_i),
        .sum_sign_o   (sum_sign),
        .sum_exp_o    (sum_exp),
        .sum_mant_o   (sum_mant),
        .round_bit_o  (sum_round),
        .sticky_bit_o (sum_sticky),
        .zero_o       (sum_zero),
        .ovf_o        (sum_ovf),
        .ufl_o        (sum_ufl)
    );

    //////////////////////////////////////////////////////////////////////
    // result select
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        res_d      = '0;
        round_d    = 1'b0;
        sticky_d   = 1'b0;
        overflow_d = 1'b0;

        if (invalid)
            res_d = fp_pkg::QNAN_DEFAULT;
        // nans come back quieted
        else if (a_nan)
            res_d = {a_i[fp_pkg::FP_WIDTH-1:fp_pkg::MANT_WIDTH], 1'b1,
                     a_i[fp_pkg::MANT_WIDTH-2:0]};
        else if (b_nan)
            res_d = {b_i[fp_pkg::FP_WIDTH-1:fp_pkg::MANT_WIDTH], 1'b1,
                     b_i[fp_pkg::MANT_WIDTH-2:0]};
        else if (c_nan)
            res_d = {c_i[fp_pkg::FP_WIDTH-1:fp_pkg::MANT_WIDTH], 1'b1,
                     c_i[fp_pkg::MANT_WIDTH-2:0]};
        else if (a_inf | b_inf)
            res_d = {prod_sign, fp_pkg::INF_EXP, {fp_pkg::MANT_WIDTH{1'b0}}};
        else if (c_inf)
            res_d = {c_sign_eff, fp_pkg::INF_EXP, {fp_pkg::MANT_WIDTH{1'b0}}};
        else if (a_zero | b_zero)
        begin
            // zero product passes c through, unlike-signed zeros follow rdn
            if (c_zero)
                res_d = {eff_sub ? (rnd_i == fp_pkg::RDN) : prod_sign,
                         {(fp_pkg::FP_WIDTH-1){1'b0}}};
            else
                res_d = {c_sign_eff, c_i[fp_pkg::FP_WIDTH-2:0]};
        end
        else if (sum_ovf)
        begin
            res_d      = {sum_sign, fp_pkg::INF_EXP, {fp_pkg::MANT_WIDTH{1'b0}}};
            overflow_d = 1'b1;
        end
        else if (sum_ufl | sum_zero)
            res_d = {sum_sign, {(fp_pkg::FP_WIDTH-1){1'b0}}};
        else
        begin
            res_d    = {sum_sign, sum_exp, sum_mant};
            round_d  = sum_round;
            sticky_d = sum_sticky;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            result_o     <= '0;
            round_bit_o  <= 1'b0;
            sticky_bit_o <= 1'b0;
            invalid_o    <= 1'b0;
            overflow_o   <= 1'b0;
            done_o       <= 1'b0;
        end
        else
        begin
            done_o <= start_i;
            if (start_i)
            begin
                result_o     <= res_d;
                round_bit_o  <= round_d;
                sticky_bit_o <= sticky_d;
                invalid_o    <= invalid;
                overflow_o   <= overflow_d;
            end
        end
    end

endmodule

/* design/fp_fma_add.sv */
`timescale 1ns/1ns

module fp_fma_add
(
    input  logic                                prod_sign_i,
    input  logic signed [fp_pkg::EXP_WIDTH+1:0] prod_exp_i,
    input  logic [fp_pkg::PROD_WIDTH-1:0]       prod_mant_i,
    input  logic                                c_sign_i,
    input  logic [fp_pkg::EXP_WIDTH-1:0]        c_exp_i,
    input  logic [fp_pkg::MANT_WIDTH-1:0]       c_mant_i,
    input  logic                                eff_sub_i,
    input  fp_pkg::round_mode_e                 rnd_i,
    output logic                                sum_sign_o,
    output logic [fp_pkg::EXP_WIDTH-1:0]        sum_exp_o,
    output logic [fp_pkg::MANT_WIDTH-1:0]       sum_mant_o,
    output logic                                round_bit_o,
    output logic                                sticky_bit_o,
    output logic                                zero_o,
    output logic                                ovf_o,
    output logic                                ufl_o
);

    logic                                                      c_zero;
    logic [fp_pkg::PROD_WIDTH-1:0]                             c_sig;
    logic signed [fp_pkg::EXP_WIDTH+1:0]                       c_exp;
    logic                                                      c_bigger;

    logic                                                      big_sign;
    logic signed [fp_pkg::EXP_WIDTH+1:0]                       big_exp;
    logic [fp_pkg::PROD_WIDTH-1:0]                             big_sig;
    logic [fp_pkg::PROD_WIDTH-1:0]                             small_sig;
    logic [fp_pkg::EXP_WIDTH+1:0]                              exp_diff;
    logic [fp_pkg::EXP_WIDTH+1:0]                              align_shift;

    logic [fp_pkg::PROD_WIDTH+fp_pkg::GUARD_BITS-1:0]          big_ext;
    logic [fp_pkg::PROD_WIDTH+fp_pkg::GUARD_BITS-1:0]          small_ext;
    logic [2*(fp_pkg::PROD_WIDTH+fp_pkg::GUARD_BITS)-1:0]      align_wide;
    logic                                                      align_sticky;

    logic [fp_pkg::PROD_WIDTH+fp_pkg::GUARD_BITS+1:0]          raw_sum;
    logic                                                      carry;
    logic [$clog2(fp_pkg::PROD_WIDTH+fp_pkg::GUARD_BITS+2)-1:0] lz_cnt;
    logic                                                      lz_zero;
    logic [fp_pkg::PROD_WIDTH+fp_pkg::GUARD_BITS:0]            norm_sum;
    logic signed [fp_pkg::EXP_WIDTH+1:0]                       res_exp;

    //////////////////////////////////////////////////////////////////////
    // operand swap
    //////////////////////////////////////////////////////////////////////

    // addend placed in the product format, leading one on the top bit
    assign c_zero = (c_exp_i == '0);
    assign c_sig  = c_zero ? '0
                  : {1'b1, c_mant_i, {(fp_pkg::PROD_WIDTH-fp_pkg::MANT_WIDTH-1){1'b0}}};
    assign c_exp  = $signed({2'b00, c_exp_i});

    // a zero addend never wins, the product may carry a negative exponent
    assign c_bigger = ~c_zero & ((c_exp > prod_exp_i) |
                                 ((c_exp == prod_exp_i) & (c_sig > prod_mant_i)));

    assign big_sign  = c_bigger ? c_sign_i    : prod_sign_i;
    assign big_exp   = c_bigger ? c_exp       : prod_exp_i;
    assign big_sig   = c_bigger ? c_sig       : prod_mant_i;
    assign small_sig = c_bigger ? prod_mant_i : c_sig;
    assign exp_diff  = c_bigger ? c_exp - prod_exp_i : prod_exp_i - c_exp;

    //////////////////////////////////////////////////////////////////////
    // alignment with sticky
    //////////////////////////////////////////////////////////////////////

    // past the full width everything lands in the sticky half
    assign align_shift =
        (exp_diff > (fp_pkg::EXP_WIDTH+2)'(fp_pkg::PROD_WIDTH + fp_pkg::GUARD_BITS)) ?
        (fp_pkg::EXP_WIDTH+2)'(fp_pkg::PROD_WIDTH + fp_pkg::GUARD_BITS) : exp_diff;

    assign big_ext   = {big_sig, {fp_pkg::GUARD_BITS{1'b0}}};
    assign small_ext = {small_sig, {fp_pkg::GUARD_BITS{1'b0}}};

    assign align_wide =
        {small_ext, {(fp_pkg::PROD_WIDTH+fp_pkg::GUARD_BITS){1'b0}}} >> align_shift;
    assign align_sticky = |align_wide[fp_pkg::PROD_WIDTH+fp_pkg::GUARD_BITS-1:0];

    // sticky enters as the lsb, below the guard bits
    always_comb
    begin
        if (eff_sub_i)
            raw_sum = {1'b0, big_ext, 1'b0}
                    - {1'b0, align_wide[$bits(align_wide)-1 -: $bits(big_ext)], align_sticky};
        else
            raw_sum = {1'b0, big_ext, 1'b0}
                    + {1'b0, align_wide[$bits(align_wide)-1 -: $bits(big_ext)], align_sticky};
    end

    //////////////////////////////////////////////////////////////////////
    // normalize
    //////////////////////////////////////////////////////////////////////

    assign carry = raw_sum[fp_pkg::PROD_WIDTH+fp_pkg::GUARD_BITS+1];

    fp_lzc
    #(
        .WIDTH (fp_pkg::PROD_WIDTH + fp_pkg::GUARD_BITS + 1)
    )
    u_lzc
    (
        .in_i       (raw_sum[fp_pkg::PROD_WIDTH+fp_pkg::GUARD_BITS:0]),
        .count_o    (lz_cnt),
        .all_zero_o (lz_zero)
    );

    always_comb
    begin
        if (carry)
        begin
            norm_sum = raw_sum[fp_pkg::PROD_WIDTH+fp_pkg::GUARD_BITS+1:1];
            res_exp  = big_exp + 1'b1;
        end
        else
        begin
            norm_sum = raw_sum[fp_pkg::PROD_WIDTH+fp_pkg::GUARD_BITS:0] << lz_cnt;
            res_exp  = big_exp - lz_cnt;
        end
    end

    // exact cancellation
    assign zero_o     = ~carry & lz_zero;
    assign sum_sign_o = zero_o ? (rnd_i == fp_pkg::RDN) : big_sign;

    // hidden one dropped, then round bit, rest is sticky
    assign sum_exp_o    = res_exp[fp_pkg::EXP_WIDTH-1:0];
    assign sum_mant_o   = norm_sum[$bits(norm_sum)-2 -: fp_pkg::MANT_WIDTH];
    assign round_bit_o  = norm_sum[$bits(norm_sum)-2-fp_pkg::MANT_WIDTH];
    assign sticky_bit_o = (|norm_sum[$bits(norm_sum)-3-fp_pkg::MANT_WIDTH:0]) |
                          (carry & raw_sum[0]);

    assign ovf_o = ~zero_o & (res_exp > (fp_pkg::EXP_MAX - 1));
    assign ufl_o = ~zero_o & (res_exp < 1);

endmodule

/* design/fp_fma_mul.sv */
`timescale 1ns/1ns

module fp_fma_mul
(
    input  logic                                a_sign_i,
    input  logic [fp_pkg::EXP_WIDTH-1:0]        a_exp_i,
    input  logic [fp_pkg::MANT_WIDTH-1:0]       a_mant_i,
    input  logic                                b_sign_i,
    input  logic [fp_pkg::EXP_WIDTH-1:0]        b_exp_i,
    input  logic [fp_pkg::MANT_WIDTH-1:0]       b_mant_i,
    output logic                                prod_sign_o,
    output logic signed [fp_pkg::EXP_WIDTH+1:0] prod_exp_o,
    output logic [fp_pkg::PROD_WIDTH-1:0]       prod_mant_o
);

    logic [fp_pkg::MANT_WIDTH:0]             a_sig;
    logic [fp_pkg::MANT_WIDTH:0]             b_sig;
    logic [fp_pkg::PROD_WIDTH-1:0]           raw_prod;
    logic                                    carry;
    logic [$clog2(fp_pkg::PROD_WIDTH+1)-1:0] lz_cnt;
    logic [fp_pkg::EXP_WIDTH+1:0]            exp_sum;

    //////////////////////////////////////////////////////////////////////
    // exact significand product
    //////////////////////////////////////////////////////////////////////

    // hidden ones, operands are normal here
    assign a_sig = {1'b1, a_mant_i};
    assign b_sig = {1'b1, b_mant_i};

    assign raw_prod    = a_sig * b_sig;
    assign prod_sign_o = a_sign_i ^ b_sign_i;

    // product lies in [1, 4), so the carry is the top bit
    assign carry = raw_prod[fp_pkg::PROD_WIDTH-1];

    fp_lzc
    #(
        .WIDTH (fp_pkg::PROD_WIDTH)
    )
    u_lzc
    (
        .in_i       (raw_prod),
        .count_o    (lz_cnt),
        .all_zero_o ()
    );

    //////////////////////////////////////////////////////////////////////
    // normalize
    //////////////////////////////////////////////////////////////////////

    // biased exponent when the leading one sits on the top bit
    assign exp_sum = {2'b00, a_exp_i} + {2'b00, b_exp_i}
                   - (fp_pkg::EXP_WIDTH+2)'(fp_pkg::BIAS - 1);

    always_comb
    begin
        if (carry)
        begin
            prod_mant_o = raw_prod;
            prod_exp_o  = exp_sum;
        end
        else
        begin
            prod_mant_o = raw_prod << lz_cnt;
            prod_exp_o  = exp_sum - (fp_pkg::EXP_WIDTH+2)'(lz_cnt);
        end
    end

endmodule

/* design/fp_lzc.sv */
`timescale 1ns/1ns

module fp_lzc
#(
    parameter int WIDTH = 48
)
(
    input  logic [WIDTH-1:0]           in_i,
    output logic [$clog2(WIDTH+1)-1:0] count_o,
    output logic                       all_zero_o
);

    logic found;

    // walk down from the msb until the first one
    always_comb
    begin
        count_o = '0;
        found   = 1'b0;
        for (int i = WIDTH - 1; i >= 0; i--)
        begin
            if (!found)
            begin
                if (in_i[i])
                    found = 1'b1;
                else
                    count_o = count_o + 1'b1;
            end
        end
    end

    // count_o equals WIDTH here
    assign all_zero_o = ~found;

endmodule

/* design/fp_pkg.sv */
package fp_pkg;

    //////////////////////////////////////////////////////////////////////
    // binary32 format
    //////////////////////////////////////////////////////////////////////

    localparam int FP_WIDTH   = 32;
    localparam int EXP_WIDTH  = 8;
    localparam int MANT_WIDTH = 23;
    localparam int BIAS       = 127;

    // 24x24 significand product
    localparam int PROD_WIDTH = 48;
    localparam int GUARD_BITS = 3;

    localparam int EXP_MAX    = 255;

    typedef logic [FP_WIDTH-1:0] fp_word_t;

    localparam fp_word_t QNAN_DEFAULT = 32'hffc0_0000;
    localparam logic [EXP_WIDTH-1:0] INF_EXP = {EXP_WIDTH{1'b1}};

    //////////////////////////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0]
    {
        FP_ZERO,
        FP_NORMAL,
        FP_INF,
        FP_QNAN,
        FP_SNAN
    } fp_class_e;

    // fmsub negates the addend
    typedef enum logic
    {
        FMADD = 1'b0,
        FMSUB = 1'b1
    } fma_op_e;

    typedef enum logic [2:0]
    {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011,
        RMM = 3'b100
    } round_mode_e;

    // zero exponent reads as zero, subnormals are flushed
    function automatic fp_class_e fp_classify(input fp_word_t word);
        logic [EXP_WIDTH-1:0]  exp_f;
        logic [MANT_WIDTH-1:0] mant_f;
        fp_class_e             cls;

        exp_f  = word[FP_WIDTH-2 -: EXP_WIDTH];
        mant_f = word[MANT_WIDTH-1:0];

        if (exp_f == '0)
            cls = FP_ZERO;
        else if (exp_f != EXP_MAX)
            cls = FP_NORMAL;
        else if (mant_f == '0)
            cls = FP_INF;
        else if (mant_f[MANT_WIDTH-1])
            cls = FP_QNAN;
        else
            cls = FP_SNAN;

        return cls;
    endfunction

endpackage

/* verification/fp_fma_assert.sv */
`timescale 1ns/1ns

module fp_fma_assert
(
    input logic             clk_i,
    input logic             rst_n_i,
    input logic             start_i,
    input fp_pkg::fp_word_t result_i,
    input logic             invalid_i,
    input logic             overflow_i,
    input logic             done_i
);

    // number of failed assertions so far
    int error_count = 0;

    // done is a one cycle echo of start
    assert property (@(posedge clk_i) disable iff (!rst_n_i) start_i |=> done_i)
        else
        begin
            error_count++;
            $error("done_o missing one cycle after start_i");
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) !start_i |=> !done_i)
        else
        begin
            error_count++;
            $error("done_o high without a start_i in the cycle before");
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     invalid_i |-> (result_i == fp_pkg::QNAN_DEFAULT))
        else
        begin
            error_count++;
            $error("invalid_o set but result_o is not the default quiet NaN");
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     overflow_i |-> (result_i[fp_pkg::FP_WIDTH-2:0] ==
                                     {fp_pkg::INF_EXP, {fp_pkg::MANT_WIDTH{1'b0}}}))
        else
        begin
            error_count++;
            $error("overflow_o set but result_o is not infinite");
        end

    assert property (@(posedge clk_i) !rst_n_i |=> !done_i)
        else
        begin
            error_count++;
            $error("done_o high during reset");
        end

endmodule

bind fp_fma fp_fma_assert u_fma_assert
(
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .start_i    (start_i),
    .result_i   (result_o),
    .invalid_i  (invalid_o),
    .overflow_i (overflow_o),
    .done_i     (done_o)
);

/* verification/fp_fma_tb.sv */
`timescale 1ns/1ns

module fp_fma_tb;

    localparam int CLK_PERIOD        = 100;
    localparam int DRIVE_DELAY       = 5;
    localparam int RESET_CYCLES      = 4;
    localparam int CYCLES_PER_VECTOR = 4;
    localparam int FIELDS            = 10;
    localparam int MAX_VECTORS       = 256;
    localparam     TEST_FILE         = "verification/fp_fma_tests.txt";

    logic                clk;
    logic                rst_n;
    logic                start;
    fp_pkg::fp_word_t    a;
    fp_pkg::fp_word_t    b;
    fp_pkg::fp_word_t    c;
    fp_pkg::fma_op_e     op;
    fp_pkg::round_mode_e rnd;
    fp_pkg::fp_word_t    result;
    logic                round_bit;
    logic                sticky_bit;
    logic                invalid;
    logic                overflow;
    logic                done;

    // one word per field and FIELDS words per vector
    logic [31:0]         vec_mem [0:MAX_VECTORS*FIELDS-1];
    int                  num_vectors;
    logic                loaded;

    fp_fma dut
    (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .start_i      (start),
        .a_i          (a),
        .b_i          (b),
        .c_i          (c),
        .op_i         (op),
        .rnd_i        (rnd),
        .result_o     (result),
        .round_bit_o  (round_bit),
        .sticky_bit_o (sticky_bit),
        .invalid_o    (invalid),
        .overflow_o   (overflow),
        .done_o       (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // reporting and compare
    //////////////////////////////////////////////////////////////////////

    task automatic end_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped after the first error");
    endtask

    task automatic check_word(input fp_pkg::fp_word_t got, input fp_pkg::fp_word_t expected,
                              input string what, input int idx);
        fp_pkg::fp_class_e got_cls;
        fp_pkg::fp_class_e exp_cls;

        got_cls = fp_pkg::fp_classify(got);
        exp_cls = fp_pkg::fp_classify(expected);
        if (got !== expected)
        begin
            $display("mismatch at %0t: vector %0d %s got %h (%s) expected %h (%s)",
                     $time, idx, what, got, got_cls.name(), expected, exp_cls.name());
            end_with_failure();
        end
    endtask

    task automatic check_bit(input logic got, input logic expected, input string what,
                             input int idx);
        if (got !== expected)
        begin
            $display("mismatch at %0t: vector %0d %s got %b expected %b",
                     $time, idx, what, got, expected);
            end_with_failure();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // vectors
    //////////////////////////////////////////////////////////////////////

    task automatic load_vectors();
        int idx;
        int k;

        for (idx = 0; idx < MAX_VECTORS * FIELDS; idx++)
            vec_mem[idx] = 'x;
        $readmemh(TEST_FILE, vec_mem);

        while (num_vectors < MAX_VECTORS && !$isunknown(vec_mem[num_vectors*FIELDS]))
            num_vectors++;

        if (num_vectors == 0)
        begin
            $display("could not read any test vectors from %s", TEST_FILE);
            end_with_failure();
        end

        for (idx = 0; idx < num_vectors; idx++)
        begin
            for (k = 0; k < FIELDS; k++)
            begin
                if ($isunknown(vec_mem[idx*FIELDS+k]))
                begin
                    $display("test vector %0d in %s is incomplete or not hex", idx, TEST_FILE);
                    end_with_failure();
                end
            end
        end
    endtask

    task automatic apply_vector(input int idx);
        int base;

        base  = idx * FIELDS;
        a     = vec_mem[base];
        b     = vec_mem[base+1];
        c     = vec_mem[base+2];
        op    = fp_pkg::fma_op_e'(vec_mem[base+3][0]);
        rnd   = fp_pkg::round_mode_e'(vec_mem[base+4][2:0]);
        start = 1'b1;
    endtask

    // fields 5 to 9 hold the expected outputs
    task automatic verify_outputs(input int idx);
        int base;

        base = idx * FIELDS;
        check_bit(done, 1'b1, "done", idx);
        check_word(result, vec_mem[base+5], "result", idx);
        check_bit(round_bit, vec_mem[base+6][0], "round bit", idx);
        check_bit(sticky_bit, vec_mem[base+7][0], "sticky bit", idx);
        check_bit(invalid, vec_mem[base+8][0], "invalid flag", idx);
        check_bit(overflow, vec_mem[base+9][0], "overflow flag", idx);
    endtask

    // outputs hold for a cycle without start
    task automatic check_idle(input int idx);
        check_bit(done, 1'b0, "done while idle", idx);
        check_word(result, vec_mem[idx*FIELDS+5], "held result", idx);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        rst_n       = 1'b0;
        start       = 1'b0;
        a           = '0;
        b           = '0;
        c           = '0;
        op          = fp_pkg::FMADD;
        rnd         = fp_pkg::RNE;
        num_vectors = 0;
        loaded      = 1'b0;

        load_vectors();
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        check_bit(done, 1'b0, "done after reset", -1);
        check_word(result, '0, "result after reset", -1);
        check_bit(invalid, 1'b0, "invalid after reset", -1);
        check_bit(overflow, 1'b0, "overflow after reset", -1);
        rst_n = 1'b1;

        // single starts with an idle cycle between them
        for (int i = 0; i < num_vectors; i++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (i > 0)
                check_idle(i - 1);
            apply_vector(i);
            @(posedge clk);
            #DRIVE_DELAY;
            start = 1'b0;
            verify_outputs(i);
        end

        // back to back with one start per cycle
        for (int i = 0; i < num_vectors; i++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (i == 0)
                check_idle(num_vectors - 1);
            else
                verify_outputs(i - 1);
            apply_vector(i);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        start = 1'b0;
        verify_outputs(num_vectors - 1);
        @(posedge clk);
        #DRIVE_DELAY;
        check_idle(num_vectors - 1);

        $display("Simulation finished: PASS");
        $finish;
    end

    initial
    begin
        wait (loaded);
        #(CLK_PERIOD * (num_vectors * CYCLES_PER_VECTOR + RESET_CYCLES + 2));
        $display("watchdog expired before all %0d test vectors were checked", num_vectors);
        end_with_failure();
    end

    // a failed bound assertion ends the run
    initial
    begin
        wait (dut.u_fma_assert.error_count != 0);
        $display("a bound assertion on the DUT outputs failed");
        end_with_failure();
    end

endmodule

/* verification/fp_fma_tests.txt */
// each line holds a b c op rnd, then the expected result round sticky invalid overflow
// all hex, op 0 is fmadd and 1 is fmsub, rnd 0 rne 1 rtz 2 rdn 3 rup 4 rmm

// exact fused results
40000000 40400000 3F800000 0 0 40E00000 0 0 0 0
40000000 40400000 3F800000 1 0 40A00000 0 0 0 0
3FC00000 3FC00000 3E800000 0 1 40200000 0 0 0 0
C0000000 40400000 41200000 0 0 40800000 0 0 0 0
40000000 40000000 41200000 1 3 C0C00000 0 0 0 0
3F000000 3F000000 3F800000 1 4 BF400000 0 0 0 0
3FC00000 40200000 3FC00000 0 2 40A80000 0 0 0 0

// inexact, product low bits survive the add
3F800001 3F800001 3F800000 0 0 40000001 0 1 0 0
40400000 3F800000 30800000 0 0 40400000 0 1 0 0
3F800000 3F800000 33800000 0 1 3F800000 1 0 0 0
3F800000 3F800000 33C00000 0 0 3F800000 1 1 0 0
3F800000 3F800000 30800000 1 0 3F7FFFFF 1 1 0 0
3F800001 3F800001 4B800000 0 0 4B800000 1 1 0 0

// exact cancellation, negative zero only for rdn
40000000 40400000 40C00000 1 0 00000000 0 0 0 0
40000000 40400000 40C00000 1 1 00000000 0 0 0 0
40000000 40400000 40C00000 1 2 80000000 0 0 0 0
40000000 40400000 40C00000 1 3 00000000 0 0 0 0
40000000 40400000 40C00000 1 4 00000000 0 0 0 0
00000000 40A00000 80000000 0 2 80000000 0 0 0 0

// nan propagation, invalid cases, infinities
7FC00001 3F800000 3F800000 0 0 7FC00001 0 0 0 0
40000000 40400000 FFC12345 0 0 FFC12345 0 0 0 0
40000000 40400000 7F800001 0 0 FFC00000 0 0 1 0
7F800000 00000000 3F800000 0 0 FFC00000 0 0 1 0
7F800000 3F800000 7F800000 1 0 FFC00000 0 0 1 0
FF800000 40000000 3F800000 0 0 FF800000 0 0 0 0
40000000 40400000 FF800000 0 0 FF800000 0 0 0 0

// overflow, zero exponent inputs, underflow to signed zero
7F000000 40800000 3F800000 0 0 7F800000 0 0 0 1
FF000000 40000000 3F800000 1 0 FF800000 0 0 0 1
00400000 40000000 3F800000 0 0 3F800000 0 0 0 0
8D800000 0D800000 00000000 0 0 80000000 0 0 0 0
